//--- filelist.f
+incdir+common
common/thumb_pkg.sv
common/exec_operand_if.sv
hw/branch/branch_controller.sv
hw/branch/branch_imm_decode.sv
hw/register_file.sv
hw/fetch_pc.sv
hw/exec_branch_top.sv
dv/tb_exec_branch.sv

//--- Bender.yml
package:
  name: exec_branch

export_include_dirs:
  - common

sources:
  - files:
      - common/thumb_pkg.sv
      - common/exec_operand_if.sv
      - hw/branch/branch_controller.sv
      - hw/branch/branch_imm_decode.sv
      - hw/register_file.sv
      - hw/fetch_pc.sv
      - hw/exec_branch_top.sv
  - target: test
    files:
      - dv/tb_exec_branch.sv

//--- dv/tb_exec_branch.sv
`include "thumb_defines.svh"

module tb_exec_branch;

    timeunit 1ns;
    timeprecision 1ps;

    import thumb_pkg::*;

    // Reset, then sequential, conditional, unconditional, hi-register,
    // long-branch, invalid-slot tests and a final PC check
    localparam int TEST_CYCLES    = 8 + 11 + 480 + 20 + 52 + 24 + 8 + 1;
    localparam int TIMEOUT_CYCLES = TEST_CYCLES + 100;

    logic     clk_i;
    logic     reset_i;
    logic     instr_valid_i;
    instr_t   instr_i;
    logic     flags_we_i;
    flags_t   flags_wdata_i;
    logic     reg_we_i;
    reg_idx_t reg_waddr_i;
    word_t    reg_wdata_i;
    word_t    pc_o;
    logic     take_branch_o;
    logic     flush_o;

    // Reference model state
    word_t  model_pc;
    word_t  model_regs [16];
    flags_t model_flags;
    logic   model_pending;
    word_t  model_upper;

    logic [31:0] lfsr;
    int          errors;
    int          checks;
    int          cycles;

    exec_branch_top exec_branch_top_i (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .flags_we_i    (flags_we_i),
        .flags_wdata_i (flags_wdata_i),
        .reg_we_i      (reg_we_i),
        .reg_waddr_i   (reg_waddr_i),
        .reg_wdata_i   (reg_wdata_i),
        .pc_o          (pc_o),
        .take_branch_o (take_branch_o),
        .flush_o       (flush_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("Timeout: run exceeded %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // ------------------------------------------------------------------
    // Helpers and reference model
    // ------------------------------------------------------------------

    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // Odd condition codes are the inverse of the even code below them
    function automatic logic cond_passes(input logic [3:0] c, input flags_t f);
        logic base;
        case (c[3:1])
            3'd0: base = f[`FLAG_Z];
            3'd1: base = f[`FLAG_C];
            3'd2: base = f[`FLAG_N];
            3'd3: base = f[`FLAG_V];
            3'd4: base = f[`FLAG_C] & ~f[`FLAG_Z];
            3'd5: base = (f[`FLAG_N] == f[`FLAG_V]);
            3'd6: base = ~f[`FLAG_Z] & (f[`FLAG_N] == f[`FLAG_V]);
            default: base = 1'b1;
        endcase
        return base ^ c[0];
    endfunction

    function automatic instr_t make_hireg(input logic [1:0] op, input reg_idx_t rd,
                                          input reg_idx_t rm);
        return {6'b010001, op, rd[3], rm, rd[2:0]};
    endfunction

    task automatic predict(input instr_t instr, output logic take, output word_t target,
                           output logic nxt_pending, output word_t nxt_upper);
        word_t    cur;
        word_t    rm_val;
        reg_idx_t rd;
        int       off;
        cur = model_pc + 4;
        take = 1'b0;
        target = '0;
        nxt_pending = model_pending;
        nxt_upper = model_upper;
        rd = {instr[7], instr[2:0]};
        rm_val = (instr[6:3] == `PC_REG_NUM) ? cur : model_regs[instr[6:3]];
        if (instr[15:12] == 4'b1101) begin
            off = $signed(instr[7:0]);
            take = cond_passes(instr[11:8], model_flags);
            target = cur + word_t'(off * 2);
        end else if (instr[15:11] == 5'b11100) begin
            off = $signed(instr[10:0]);
            take = 1'b1;
            target = cur + word_t'(off * 2);
        end else if (instr[15:10] == 6'b010001) begin
            case (instr[9:8])
                ADD_HI: begin
                    take = (rd == 4'd15);
                    target = cur + rm_val;
                end
                MOV_HI: begin
                    take = (rd == 4'd15);
                    target = rm_val;
                end
                default: begin
                    take = 1'b1;
                    target = rm_val;
                end
            endcase
        end else if (instr[15:11] >= 5'b11101) begin
            if (model_pending) begin
                take = 1'b1;
                target = cur + model_upper + word_t'({instr[10:0], 1'b0});
                nxt_pending = 1'b0;
            end else begin
                off = $signed(instr[10:0]);
                nxt_upper = word_t'(off) << 12;
                nxt_pending = 1'b1;
            end
        end
    endtask

    // Every cycle starts on the falling edge with a PC check
    task automatic begin_cycle();
        @(negedge clk_i);
        checks++;
        if (pc_o !== model_pc) begin
            errors++;
            $display("Error pc_o: got %h, expected %h at %0t", pc_o, model_pc, $time);
        end
        instr_valid_i = 1'b0;
        flags_we_i = 1'b0;
        reg_we_i = 1'b0;
    endtask

    task automatic set_flags(input flags_t f);
        begin_cycle();
        flags_we_i = 1'b1;
        flags_wdata_i = f;
        model_flags = f;
    endtask

    task automatic write_reg(input reg_idx_t idx, input word_t val);
        begin_cycle();
        reg_we_i = 1'b1;
        reg_waddr_i = idx;
        reg_wdata_i = val;
        if (idx != `PC_REG_NUM) begin
            model_regs[idx] = val;
        end
    endtask

    task automatic issue(input logic v, input instr_t instr);
        logic  exp_take;
        word_t exp_target;
        logic  nxt_pending;
        word_t nxt_upper;
        begin_cycle();
        instr_valid_i = v;
        instr_i = instr;
        predict(instr, exp_take, exp_target, nxt_pending, nxt_upper);
        exp_take = exp_take & v;
        #2;
        checks++;
        if (take_branch_o !== exp_take) begin
            errors++;
            $display("Error take_branch_o: got %h, expected %h for instr %h",
                     take_branch_o, exp_take, instr);
        end
        checks++;
        if (flush_o !== exp_take) begin
            errors++;
            $display("Error flush_o: got %h, expected %h for instr %h", flush_o, exp_take, instr);
        end
        if (v) begin
            model_pc = exp_take ? {exp_target[31:1], 1'b0} : model_pc + 2;
            model_pending = nxt_pending;
            model_upper = nxt_upper;
        end
    endtask

    // ------------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------------

    task automatic sequential_steps();
        repeat (6) issue(1'b1, 16'h1c08);
        repeat (3) issue(1'b0, 16'h2001);
        issue(1'b1, 16'h2001);
        issue(1'b1, 16'h4008);
    endtask

    task automatic conditional_branches();
        logic [31:0] rnd;
        for (int c = 0; c < 15; c++) begin
            for (int f = 0; f < 16; f++) begin
                set_flags(flags_t'(f));
                rnd = lfsr_bits(8);
                issue(1'b1, {4'b1101, 4'(c), rnd[7:0]});
            end
        end
    endtask

    task automatic unconditional_branches();
        logic [31:0] rnd;
        repeat (20) begin
            rnd = lfsr_bits(11);
            issue(1'b1, {5'b11100, rnd[10:0]});
        end
    endtask

    task automatic hireg_branches();
        logic [31:0] rnd;
        reg_idx_t    dest;
        for (int r = 0; r < 16; r++) begin
            write_reg(reg_idx_t'(r), lfsr_bits(32));
        end
        repeat (6) begin
            rnd = lfsr_bits(4);
            issue(1'b1, make_hireg(ADD_HI, 4'd15, rnd[3:0]));
            rnd = lfsr_bits(4);
            issue(1'b1, make_hireg(MOV_HI, 4'd15, rnd[3:0]));
            rnd = lfsr_bits(4);
            issue(1'b1, make_hireg(BX_OP, 4'd0, rnd[3:0]));
            rnd = lfsr_bits(4);
            issue(1'b1, make_hireg(BLX_OP, 4'd0, rnd[3:0]));
            rnd = lfsr_bits(8);
            dest = (rnd[7:4] == 4'd15) ? 4'd14 : rnd[7:4];
            issue(1'b1, make_hireg(ADD_HI, dest, rnd[3:0]));
            issue(1'b1, make_hireg(MOV_HI, dest, rnd[3:0]));
        end
    endtask

    task automatic long_branch_pairs();
        logic [31:0] rnd;
        for (int i = 0; i < 8; i++) begin
            rnd = lfsr_bits(11);
            issue(1'b1, {5'b11110, rnd[10:0]});
            rnd = lfsr_bits(12);
            // A bubble between the two words must keep the pending state
            if (rnd[11]) begin
                issue(1'b0, {5'b11111, rnd[10:0]});
            end
            issue(1'b1, {(i[0] ? 5'b11101 : 5'b11111), rnd[10:0]});
        end
    endtask

    task automatic invalid_slots();
        issue(1'b0, 16'hde10);
        issue(1'b0, 16'he3f0);
        issue(1'b0, make_hireg(BX_OP, 4'd0, 4'd3));
        issue(1'b0, 16'hf123);
        issue(1'b1, 16'h1c08);
        issue(1'b1, 16'hf7ff);
        issue(1'b0, 16'hf804);
        issue(1'b1, 16'hf804);
    endtask

    initial begin
        reset_i = 1'b1;
        instr_valid_i = 1'b0;
        instr_i = '0;
        flags_we_i = 1'b0;
        flags_wdata_i = '0;
        reg_we_i = 1'b0;
        reg_waddr_i = '0;
        reg_wdata_i = '0;
        model_pc = `RESET_PC;
        for (int i = 0; i < 16; i++) begin
            model_regs[i] = '0;
        end
        model_flags = '0;
        model_pending = 1'b0;
        model_upper = '0;
        lfsr = 32'hbcb2_d4eb;
        errors = 0;
        checks = 0;
        cycles = 0;

        repeat (8) @(negedge clk_i);
        reset_i = 1'b0;

        sequential_steps();
        conditional_branches();
        unconditional_branches();
        hireg_branches();
        long_branch_pairs();
        invalid_slots();
        begin_cycle();

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- hw/exec_branch_top.sv
module exec_branch_top (
    input  logic                clk_i,
    input  logic                reset_i,
    input  logic                instr_valid_i,
    input  thumb_pkg::instr_t   instr_i,
    input  logic                flags_we_i,
    input  thumb_pkg::flags_t   flags_wdata_i,
    input  logic                reg_we_i,
    input  thumb_pkg::reg_idx_t reg_waddr_i,
    input  thumb_pkg::word_t    reg_wdata_i,
    output thumb_pkg::word_t    pc_o,
    output logic                take_branch_o,
    output logic                flush_o
);

    import thumb_pkg::*;

    flags_t flags_q;
    logic   take_branch;
    word_t  target;

    exec_operand_if ops ();

    assign ops.valid = instr_valid_i;
    assign ops.instr = instr_i;

    // Status flags come from the ALU side through the write port
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            flags_q <= '0;
        end else if (flags_we_i) begin
            flags_q <= flags_wdata_i;
        end
    end

    // ------------------------------------------------------------------
    // Blocks
    // ------------------------------------------------------------------

    fetch_pc fetch_pc_i (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .valid_i       (instr_valid_i),
        .take_branch_i (take_branch),
        .target_i      (target),
        .ops_i         (ops.fetch),
        .pc_o          (pc_o)
    );

    register_file register_file_i (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .we_i    (reg_we_i),
        .waddr_i (reg_waddr_i),
        .wdata_i (reg_wdata_i),
        .ops_i   (ops.regfile)
    );

    branch_imm_decode branch_imm_decode_i (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .ops_i   (ops.decode)
    );

    branch_controller branch_controller_i (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .ops_i         (ops.branch),
        .flags_i       (flags_q),
        .take_branch_o (take_branch),
        .flush_o       (flush_o),
        .target_o      (target)
    );

    assign take_branch_o = take_branch;

endmodule

//--- hw/fetch_pc.sv
`include "thumb_defines.svh"

module fetch_pc (
    input  logic             clk_i,
    input  logic             reset_i,
    input  logic             valid_i,
    input  logic             take_branch_i,
    input  thumb_pkg::word_t target_i,
    exec_operand_if.fetch    ops_i,
    output thumb_pkg::word_t pc_o
);

    import thumb_pkg::*;

    word_t pc_q;

    // The PC stays halfword aligned and bit 0 of a target never reaches it
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pc_q <= `RESET_PC;
        end else if (valid_i) begin
            if (take_branch_i) begin
                pc_q <= {target_i[`WORD-1:1], 1'b0};
            end else begin
                pc_q <= pc_q + 32'd2;
            end
        end
    end

    assign pc_o = pc_q;

    // An instruction reads r15 two halfwords ahead of its own address
    assign ops_i.pc = pc_q + 32'd4;

endmodule

//--- hw/register_file.sv
`include "thumb_defines.svh"

module register_file (
    input  logic                clk_i,
    input  logic                reset_i,
    input  logic                we_i,
    input  thumb_pkg::reg_idx_t waddr_i,
    input  thumb_pkg::word_t    wdata_i,
    exec_operand_if.regfile     ops_i
);

    import thumb_pkg::*;

    word_t    regs [16];
    reg_idx_t rm_idx;

    assign rm_idx = ops_i.instr[6:3];

    // The PC lives in fetch_pc, so r15 is never written here
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != `PC_REG_NUM) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    always_comb begin
        if (rm_idx == `PC_REG_NUM) begin
            ops_i.rm_data = ops_i.pc;
        end else begin
            ops_i.rm_data = regs[rm_idx];
        end
    end

endmodule

//--- hw/branch/branch_imm_decode.sv
`include "thumb_defines.svh"

module branch_imm_decode (
    input  logic           clk_i,
    input  logic           reset_i,
    exec_operand_if.decode ops_i
);

    import thumb_pkg::*;

    link_state_e pending_q;
    word_t       upper_q;
    word_t       upper_d;
    logic        is_long;

    assign is_long = (ops_i.instr[15:11] == 5'b11101) ||
                     (ops_i.instr[15:11] == 5'b11110) ||
                     (ops_i.instr[15:11] == 5'b11111);

    // The first long-branch word places its offset in the upper bits
    assign upper_d = {{(`WORD-23){ops_i.instr[10]}}, ops_i.instr[10:0], 12'b0};

    always_comb begin
        ops_i.imm = '0;
        if (ops_i.instr[15:12] == 4'b1101) begin
            ops_i.imm = {{(`WORD-9){ops_i.instr[7]}}, ops_i.instr[7:0], 1'b0};
        end else if (ops_i.instr[15:11] == 5'b11100) begin
            ops_i.imm = {{(`WORD-12){ops_i.instr[10]}}, ops_i.instr[10:0], 1'b0};
        end else if (is_long) begin
            if (pending_q == LINK_PENDING) begin
                // Second word adds its unsigned low half to the stored upper part
                ops_i.imm = upper_q + {{(`WORD-12){1'b0}}, ops_i.instr[10:0], 1'b0};
            end else begin
                ops_i.imm = upper_d;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pending_q <= NO_LINK_PENDING;
        end else if (ops_i.valid && is_long) begin
            pending_q <= (pending_q == LINK_PENDING) ? NO_LINK_PENDING : LINK_PENDING;
        end
    end

    always_ff @(posedge clk_i) begin
        if (ops_i.valid && is_long && pending_q == NO_LINK_PENDING) begin
            upper_q <= upper_d;
        end
    end

endmodule

//--- hw/branch/branch_controller.sv
`include "thumb_defines.svh"

module branch_controller (
    input  logic               clk_i,
    input  logic               reset_i,
    exec_operand_if.branch     ops_i,
    input  thumb_pkg::flags_t  flags_i,
    output logic               take_branch_o,
    output logic               flush_o,
    output thumb_pkg::word_t   target_o
);

    import thumb_pkg::*;

    link_state_e link_q;
    link_state_e link_d;
    cond_e       cond;
    special_op_e sop;
    reg_idx_t    rd;
    logic        take;

    function automatic logic cond_holds(input cond_e c, input flags_t f);
        logic n;
        logic z;
        logic cy;
        logic v;
        logic hold;
        n  = f[`FLAG_N];
        z  = f[`FLAG_Z];
        cy = f[`FLAG_C];
        v  = f[`FLAG_V];
        case (c)
            EQ:      hold = z;
            NE:      hold = !z;
            CS:      hold = cy;
            CC:      hold = !cy;
            MI:      hold = n;
            PL:      hold = !n;
            VS:      hold = v;
            VC:      hold = !v;
            HI:      hold = cy && !z;
            LS:      hold = !cy || z;
            GE:      hold = (n == v);
            LT:      hold = (n != v);
            GT:      hold = !z && (n == v);
            LE:      hold = z || (n != v);
            AL:      hold = 1'b1;
            default: hold = 1'b0;
        endcase
        return hold;
    endfunction

    // ------------------------------------------------------------------
    // Branch decision and target
    // ------------------------------------------------------------------

    always_comb begin
        cond     = cond_e'(ops_i.instr[11:8]);
        sop      = special_op_e'(ops_i.instr[9:8]);
        rd       = {ops_i.instr[7], ops_i.instr[2:0]};
        take     = 1'b0;
        link_d   = link_q;
        // Relative forms all land at pc plus the decoded immediate
        target_o = ops_i.pc + ops_i.imm;

        casez (ops_i.instr[15:11])
            5'b1101?: begin
                take = cond_holds(cond, flags_i);
            end
            5'b11100: begin
                take = 1'b1;
            end
            5'b01000: begin
                if (ops_i.instr[10]) begin
                    case (sop)
                        ADD_HI: begin
                            take     = (rd == `PC_REG_NUM);
                            target_o = ops_i.pc + ops_i.rm_data;
                        end
                        MOV_HI: begin
                            take     = (rd == `PC_REG_NUM);
                            target_o = ops_i.rm_data;
                        end
                        default: begin
                            take     = 1'b1;
                            target_o = ops_i.rm_data;
                        end
                    endcase
                end
            end
            5'b11101, 5'b11110, 5'b11111: begin
                if (link_q == LINK_PENDING) begin
                    take   = 1'b1;
                    link_d = NO_LINK_PENDING;
                end else begin
                    link_d = LINK_PENDING;
                end
            end
            default: ;
        endcase
    end

    // An invalid slot never redirects
    assign take_branch_o = ops_i.valid & take;
    assign flush_o       = ops_i.valid & take;

    // ------------------------------------------------------------------
    // Long-branch sequencing
    // ------------------------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            link_q <= NO_LINK_PENDING;
        end else if (ops_i.valid) begin
            link_q <= link_d;
        end
    end

endmodule

//--- common/exec_operand_if.sv
interface exec_operand_if;

    import thumb_pkg::*;

    logic   valid;
    instr_t instr;
    word_t  pc;
    word_t  rm_data;
    word_t  imm;

    modport fetch (
        output pc
    );

    // r15 reads back as the PC, so the register file sees pc as well
    modport regfile (
        input  instr,
        input  pc,
        output rm_data
    );

    modport decode (
        input  valid,
        input  instr,
        output imm
    );

    modport branch (
        input valid,
        input instr,
        input pc,
        input rm_data,
        input imm
    );

endinterface

//--- common/thumb_pkg.sv
`include "thumb_defines.svh"

package thumb_pkg;

    // ------------------------------------------------------------------
    // Plain vector types
    // ------------------------------------------------------------------

    typedef logic [`WORD-1:0]    word_t;
    typedef logic [`INSTR_W-1:0] instr_t;

    // Laid out as N Z C V from bit 3 down to bit 0
    typedef logic [3:0]          flags_t;

    typedef logic [3:0]          reg_idx_t;

    // ------------------------------------------------------------------
    // Instruction field encodings
    // ------------------------------------------------------------------

    // Condition field of the conditional branch, bits 11 to 8
    typedef enum logic [3:0] {
        EQ = 4'h0,
        NE = 4'h1,
        CS = 4'h2,
        CC = 4'h3,
        MI = 4'h4,
        PL = 4'h5,
        VS = 4'h6,
        VC = 4'h7,
        HI = 4'h8,
        LS = 4'h9,
        GE = 4'ha,
        LT = 4'hb,
        GT = 4'hc,
        LE = 4'hd,
        AL = 4'he
    } cond_e;

    // Hi-register operation field, bits 9 to 8
    // Code 01 carries BLX in this core since it has no hi-register compare
    typedef enum logic [1:0] {
        ADD_HI = 2'b00,
        BLX_OP = 2'b01,
        MOV_HI = 2'b10,
        BX_OP  = 2'b11
    } special_op_e;

    // Set by the first word of a long branch and cleared by the second
    typedef enum logic {
        NO_LINK_PENDING = 1'b0,
        LINK_PENDING    = 1'b1
    } link_state_e;

endpackage

//--- common/thumb_defines.svh
`ifndef THUMB_DEFINES_SVH
`define THUMB_DEFINES_SVH

// Datapath and instruction widths
`define WORD    32
`define INSTR_W 16

// Address of the first instruction after reset
`define RESET_PC 32'h0000_0000

// r15 is the program counter
`define PC_REG_NUM 4'd15

// Bit positions inside the NZCV status word
`define FLAG_N 3
`define FLAG_Z 2
`define FLAG_C 1
`define FLAG_V 0

`endif
